// File: Makefile
# Verilator build for the pulse timer testbench
VERILATOR ?= verilator
TOP       ?= pulseTimerTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard rtl/*.sv tests/*.sv tests/*.svh)
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# result comes from the log, not the exit status
run: compile
	-./$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/pulseChannel.sv
`timescale 1ns/1ps

module pulseChannel (
    input  logic                            iSysClk,
    input  logic                            reset,
    input  logic                            tick,
    input  logic [pulsePkg::periodBits-1:0] period,
    input  logic                            startLevel,
    input  logic                            enable,
    input  logic                            restart,
    output logic                            pulse
);

    import pulsePkg::*;

    // ----------------------------------------
    // count qualifiers
    // ----------------------------------------

    // ticks seen since the last toggle or restart
    logic [periodBits-1:0] tickCount;
    // channel is allowed to count
    logic                  runOk;
    // this tick is the one that reaches period
    logic                  hitPeriod;

    // zero period means frozen, same as enable low
    assign runOk = enable && (period != '0);

    // count is one short of period on the last tick
    assign hitPeriod = tick && runOk && (tickCount == (period - 1'b1));

    // ----------------------------------------
    // tick counter
    // ----------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            tickCount <= '0;
        end
        else if (restart)
        begin
            // restart wins over counting
            tickCount <= '0;
        end
        else if (hitPeriod)
        begin
            tickCount <= '0;
        end
        else if (tick && runOk)
        begin
            tickCount <= tickCount + 1'b1;
        end
    end

    // ----------------------------------------
    // square-wave output
    // ----------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            pulse <= 1'b0;
        end
        else if (restart)
        begin
            // reload the programmed start level
            pulse <= startLevel;
        end
        else if (hitPeriod)
        begin
            pulse <= ~pulse;
        end
    end

endmodule

// File: rtl/pulseConfigRegs.sv
`timescale 1ns/1ps

module pulseConfigRegs (
    input  logic                                iSysClk,
    input  logic                                reset,
    input  logic                                cfgWrite,
    input  pulsePkg::cfgOp_t                    cfgOp,
    input  logic [pulsePkg::chanIdxBits-1:0]    cfgChannel,
    input  logic [7:0]                          cfgData,
    output logic [pulsePkg::periodBits-1:0]     period [pulsePkg::numChannels],
    output logic [pulsePkg::numChannels-1:0]    startLevel,
    output logic [pulsePkg::numChannels-1:0]    enable,
    output logic [pulsePkg::numChannels-1:0]    restart
);

    import pulsePkg::*;

    // ----------------------------------------
    // per-channel settings
    // ----------------------------------------

    // period, start level and enable per channel
    // only the addressed channel changes on a write
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            for (int ch = 0; ch < numChannels; ch++)
            begin
                period[ch] <= '0;
            end
            startLevel <= '0;
            // channels run by default, idle only because period is 0
            enable     <= '1;
        end
        else if (cfgWrite)
        begin
            case (cfgOp)
                CFG_PERIOD:
                begin
                    period[cfgChannel] <= periodBits'(cfgData);
                end
                CFG_START:
                begin
                    startLevel[cfgChannel] <= cfgData[0];
                end
                CFG_ENABLE:
                begin
                    enable[cfgChannel] <= cfgData[0];
                end
                default:
                begin
                    // unused opcode, ignored
                end
            endcase
        end
    end

    // ----------------------------------------
    // restart strobes
    // ----------------------------------------

    // one-cycle pulse to the addressed channel
    // period or start level write restarts the wave
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            restart <= '0;
        end
        else
        begin
            // every bit drops back after one cycle
            restart <= '0;
            if (cfgWrite && ((cfgOp == CFG_PERIOD) || (cfgOp == CFG_START)))
            begin
                restart[cfgChannel] <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/pulsePkg.sv
package pulsePkg;

    // ----------------------------------------
    // channel bank sizing
    // ----------------------------------------

    // number of square-wave outputs
    localparam int numChannels = 4;
    // bits needed to address one channel
    localparam int chanIdxBits = 2;

    // ----------------------------------------
    // timing
    // ----------------------------------------

    // system clocks per prescaler tick, kept small for simulation
    localparam int tickDivide = 4;
    // prescaler counter width, holds 0 .. tickDivide-1
    localparam int tickCntBits = (tickDivide > 2) ? $clog2(tickDivide) : 1;
    // half period in ticks, also the channel counter width
    localparam int periodBits = 8;

    // ----------------------------------------
    // configuration opcodes
    // ----------------------------------------
    typedef enum logic [1:0] {
        CFG_PERIOD = 2'd0,
        CFG_START  = 2'd1,
        CFG_ENABLE = 2'd2
    } cfgOp_t;

endpackage

// File: rtl/pulseTimerTop.sv
`timescale 1ns/1ps

module pulseTimerTop (
    input  logic                                iSysClk,
    input  logic                                reset,
    input  logic                                cfgWrite,
    input  pulsePkg::cfgOp_t                    cfgOp,
    input  logic [pulsePkg::chanIdxBits-1:0]    cfgChannel,
    input  logic [7:0]                          cfgData,
    output logic [pulsePkg::numChannels-1:0]    pulses
);

    import pulsePkg::*;

    // ----------------------------------------
    // internal wiring
    // ----------------------------------------

    // shared clock enable for all channels
    logic                   tick;
    // settings from the config block
    logic [periodBits-1:0]  period [numChannels];
    logic [numChannels-1:0] startLevel;
    logic [numChannels-1:0] enable;
    logic [numChannels-1:0] restart;

    // ----------------------------------------
    // prescaler
    // ----------------------------------------
    tickPrescaler tickPrescaler_i (
        .iSysClk (iSysClk),
        .reset   (reset),
        .tick    (tick)
    );

    // ----------------------------------------
    // configuration registers
    // ----------------------------------------
    pulseConfigRegs pulseConfigRegs_i (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .cfgWrite   (cfgWrite),
        .cfgOp      (cfgOp),
        .cfgChannel (cfgChannel),
        .cfgData    (cfgData),
        .period     (period),
        .startLevel (startLevel),
        .enable     (enable),
        .restart    (restart)
    );

    // ----------------------------------------
    // pulse channels
    // ----------------------------------------

    // one generator per output bit
    for (genvar ch = 0; ch < numChannels; ch++)
    begin : genChannel
        pulseChannel pulseChannel_i (
            .iSysClk    (iSysClk),
            .reset      (reset),
            .tick       (tick),
            .period     (period[ch]),
            .startLevel (startLevel[ch]),
            .enable     (enable[ch]),
            .restart    (restart[ch]),
            .pulse      (pulses[ch])
        );
    end

endmodule

// File: rtl/tickPrescaler.sv
`timescale 1ns/1ps

module tickPrescaler (
    input  logic iSysClk,
    input  logic reset,
    output logic tick
);

    import pulsePkg::*;

    // ----------------------------------------
    // free-running divider
    // ----------------------------------------

    // counts 0 .. tickDivide-1 then wraps
    logic [tickCntBits-1:0] divCount;
    logic                   divWrap;

    // last count of the divide cycle
    assign divWrap = (divCount == tickCntBits'(tickDivide - 1));

    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            divCount <= '0;
        end
        else if (divWrap)
        begin
            divCount <= '0;
        end
        else
        begin
            divCount <= divCount + 1'b1;
        end
    end

    // ----------------------------------------
    // tick output
    // ----------------------------------------

    // registered so the first tick lands tickDivide edges after reset
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            tick <= 1'b0;
        end
        else
        begin
            tick <= divWrap;
        end
    end

endmodule

// File: tests/pulseTimerChecks.svh
`ifndef PULSE_TIMER_CHECKS_SVH
`define PULSE_TIMER_CHECKS_SVH

// ----------------------------------------
// random source
// ----------------------------------------

// xorshift32, steps rngState in place
function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

// ----------------------------------------
// failure exits and value checks
// ----------------------------------------

// report the cause, then end the run
task automatic stopRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
endtask

// compare one observed value with its expected value
task automatic checkEq(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
        stopRun($sformatf("ERR %0t %s expected %0h actual %0h",
                          $time, name, expected, actual));
    end
endtask

// ----------------------------------------
// timed edge waits
// ----------------------------------------

// call on a falling edge, returns cycles until pulses[ch] changes
task automatic waitToggle(input int ch, input int limit, output int cycles);
    logic startBit;
    startBit = pulses[ch];
    cycles   = 0;
    while (pulses[ch] === startBit)
    begin
        if (cycles >= limit)
        begin
            stopRun($sformatf("channel %0d never toggled within %0d cycles", ch, limit));
        end
        @(negedge iSysClk);
        cycles++;
    end
endtask

`endif

// File: tests/pulseTimerTb.sv
`timescale 1ns/1ps

module pulseTimerTb;

    import pulsePkg::*;

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic                   iSysClk;
    logic                   reset;
    logic                   cfgWrite;
    cfgOp_t                 cfgOp;
    logic [chanIdxBits-1:0] cfgChannel;
    logic [7:0]             cfgData;
    logic [numChannels-1:0] pulses;

    // xorshift state
    logic [31:0] rngState;
    // channel 0 period for the freeze test
    int          period0;

    `include "pulseTimerChecks.svh"

    pulseTimerTop pulseTimerTop_i (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .cfgWrite   (cfgWrite),
        .cfgOp      (cfgOp),
        .cfgChannel (cfgChannel),
        .cfgData    (cfgData),
        .pulses     (pulses)
    );

    // 40 ns clock
    always #20 iSysClk = ~iSysClk;

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------

    // one-cycle write strobe driven on falling edges
    task automatic writeCfg(input cfgOp_t op, input int ch, input int data);
        @(negedge iSysClk);
        cfgWrite   = 1'b1;
        cfgOp      = op;
        cfgChannel = chanIdxBits'(ch);
        cfgData    = 8'(data);
        @(negedge iSysClk);
        cfgWrite   = 1'b0;
    endtask

    // period in 1 .. 12
    function automatic int randPeriod();
        return int'(nextRand() % 32'd12) + 1;
    endfunction

    // sync to one toggle then check count full intervals
    task automatic checkInterval(input int ch, input int per, input int count);
        int cycles;
        int limit;
        limit = 2 * per * tickDivide + 8;
        waitToggle(ch, limit, cycles);
        repeat (count)
        begin
            waitToggle(ch, limit, cycles);
            checkEq($sformatf("pulses[%0d] interval", ch), per * tickDivide, cycles);
        end
    endtask

    // one interval of channel ch with a period write to another channel inside it
    task automatic checkIntervalAcrossWrite(input int ch, input int per,
                                            input int otherCh, input int otherPer);
        int cycles;
        int limit;
        limit = 2 * per * tickDivide + 8;
        waitToggle(ch, limit, cycles);
        writeCfg(CFG_PERIOD, otherCh, otherPer);
        waitToggle(ch, limit, cycles);
        // the write strobe took two of the interval's cycles
        checkEq($sformatf("pulses[%0d] interval across write", ch),
                per * tickDivide, cycles + 2);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    // nothing moves while all periods are 0
    task automatic testResetState();
        checkEq("pulses", 0, pulses);
        repeat (3 * tickDivide)
        begin
            @(negedge iSysClk);
            checkEq("pulses", 0, pulses);
        end
    endtask

    task automatic testToggleInterval();
        period0 = randPeriod();
        writeCfg(CFG_PERIOD, 0, period0);
        checkInterval(0, period0, 3);
    endtask

    // start level reload and first toggle window on channel 1
    task automatic testStartRestart();
        int per;
        int cycles;
        per = randPeriod();
        writeCfg(CFG_PERIOD, 1, per);
        // two toggles bring the output back low
        waitToggle(1, per * tickDivide + 8, cycles);
        waitToggle(1, per * tickDivide + 8, cycles);
        checkEq("pulses[1]", 0, pulses[1]);
        writeCfg(CFG_START, 1, 1);
        @(negedge iSysClk);
        checkEq("pulses[1]", 1, pulses[1]);
        waitToggle(1, per * tickDivide + 4, cycles);
        if ((cycles < (per - 1) * tickDivide + 1) || (cycles > per * tickDivide))
        begin
            stopRun($sformatf("channel 1 first toggle after restart came after %0d cycles",
                              cycles));
        end
    endtask

    task automatic testEnableFreeze();
        logic held;
        writeCfg(CFG_ENABLE, 0, 0);
        held = pulses[0];
        repeat (3 * period0 * tickDivide)
        begin
            @(negedge iSysClk);
            checkEq("pulses[0] while disabled", held, pulses[0]);
        end
        writeCfg(CFG_ENABLE, 0, 1);
        checkInterval(0, period0, 2);
    endtask

    // distinct periods, the last channel rewritten inside each other channel's interval
    task automatic testIndependent();
        int   per [numChannels];
        int   pick;
        logic dup;
        for (int ch = 0; ch < numChannels; ch++)
        begin
            dup = 1'b1;
            while (dup)
            begin
                pick = randPeriod();
                dup  = 1'b0;
                for (int k = 0; k < ch; k++)
                begin
                    if (per[k] == pick)
                    begin
                        dup = 1'b1;
                    end
                end
            end
            per[ch] = pick;
            writeCfg(CFG_PERIOD, ch, pick);
        end
        for (int ch = 0; ch < numChannels; ch++)
        begin
            checkInterval(ch, per[ch], 2);
        end
        for (int ch = 0; ch < numChannels - 1; ch++)
        begin
            per[numChannels - 1] = randPeriod();
            checkIntervalAcrossWrite(ch, per[ch], numChannels - 1, per[numChannels - 1]);
        end
        checkInterval(numChannels - 1, per[numChannels - 1], 2);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial
    begin
        iSysClk    = 1'b0;
        reset      = 1'b1;
        cfgWrite   = 1'b0;
        cfgOp      = CFG_PERIOD;
        cfgChannel = '0;
        cfgData    = '0;
        rngState   = 32'h6127_b104;
        period0    = 1;
        // three rising edges in reset
        repeat (3) @(negedge iSysClk);
        reset = 1'b0;
        testResetState();
        testToggleInterval();
        testStartRestart();
        testEnableFreeze();
        testIndependent();
        $display("Test passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tests
rtl/pulsePkg.sv
rtl/tickPrescaler.sv
rtl/pulseConfigRegs.sv
rtl/pulseChannel.sv
rtl/pulseTimerTop.sv
tests/pulseTimerTb.sv
